//--- src/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// region codes, compared against adr[31:28]
`define REGION_VECT 4'h0
`define REGION_ROM 4'h1
`define REGION_IO 4'h4
`define REGION_SMEM 4'hc

// memory depths in words
`define VECT_DEPTH 32
`define ROM_DEPTH 256
`define SMEM_DEPTH 1024

`define DATA_W 32
`define ONCHIP_ACK_LAT 2
`define SMEM_LATENCY 2
`define FRAME_WORDS 64
`define IO_IRQ_W 2

`endif

//--- src/soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

  // encodings follow the chip select numbering of the wider system
  typedef enum logic [3:0] {
    CS_NONE = 4'h0,
    CS_VECT = 4'h1,
    CS_ROM  = 4'h2,
    CS_IO   = 4'h4,
    CS_SMEM = 4'h6
  } chip_sel_t;

  // master request, strobes travel separately
  typedef struct packed {
    logic [31:0]         adr;
    logic [`DATA_W-1:0]  dat;
    logic [3:0]          sel;
    logic                we;
  } bus_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0]  dat;
    logic                ack;
  } bus_rsp_t;

endpackage

//--- src/addr_decode.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module addr_decode (
  input  logic [31:0]       adr_i,
  input  logic              cyc_i,
  output soc_pkg::chip_sel_t chip_sel_o,
  output logic              fault_o
);

  import soc_pkg::*;

  always_comb begin
    chip_sel_o = CS_NONE;
    fault_o = 1'b0;
    // idle bus selects nothing and never faults
    if (cyc_i) begin
      case (adr_i[31:28])
        `REGION_VECT: chip_sel_o = CS_VECT;
        `REGION_ROM:  chip_sel_o = CS_ROM;
        `REGION_IO:   chip_sel_o = CS_IO;
        `REGION_SMEM: chip_sel_o = CS_SMEM;
        default: begin
          chip_sel_o = CS_NONE;
          fault_o = 1'b1;
        end
      endcase
    end
  end

endmodule

//--- src/onchip_mem.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module onchip_mem #(
  parameter int DEPTH = 32
) (
  input  logic                     sysclock,
  input  logic                     rst_i,
  input  logic                     rden_i,
  input  logic                     clear_i,
  input  logic [$clog2(DEPTH)-1:0] adr_i,
  output logic [31:0]              dat_o,
  output logic                     ack_o
);

  localparam int ACK_LAT = `ONCHIP_ACK_LAT;

  logic [31:0]        mem [DEPTH];
  logic [ACK_LAT-1:0] ack_q;

  // fixed contents, depth tagged in the top byte
  initial begin
    for (int n = 0; n < DEPTH; n++) begin
      mem[n] = 32'(n) * 32'h0101_0101 + (32'(DEPTH) << 24);
    end
  end

  always_ff @(posedge sysclock) begin
    if (rden_i) begin
      dat_o <= mem[adr_i];
    end
  end

  // read strobe walks through the ack pipe
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= '0;
    end else if (clear_i) begin
      ack_q <= '0;
    end else begin
      ack_q <= {ack_q[ACK_LAT-2:0], rden_i};
    end
  end

  assign ack_o = ack_q[ACK_LAT-1];

endmodule

//--- src/io_regs.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module io_regs (
  input  logic                  sysclock,
  input  logic                  rst_i,
  input  soc_pkg::bus_req_t     req_i,
  input  logic                  stb_i,
  input  logic                  cyc_i,
  output soc_pkg::bus_rsp_t     rsp_o,
  input  logic [15:0]           sw_i,
  input  logic [`IO_IRQ_W-1:0]  evt_i,
  output logic [8:0]            led_o,
  output logic [`IO_IRQ_W-1:0]  irq_o
);

  import soc_pkg::*;

  logic [8:0]           led_q;
  logic [`IO_IRQ_W-1:0] ien_q, pend_q, evt_q, evt_rise;
  logic [31:0]          rdata_d, rdata_q;
  logic                 ack_q, acc;

  // one access per request, ack holds off a repeat
  assign acc = stb_i & cyc_i & ~ack_q;
  assign evt_rise = evt_i & ~evt_q;

  always_comb begin
    rdata_d = '0;
    case (req_i.adr[3:2])
      2'd0: rdata_d[15:0] = sw_i;
      2'd1: rdata_d[8:0] = led_q;
      2'd2: rdata_d[`IO_IRQ_W-1:0] = ien_q;
      default: rdata_d[`IO_IRQ_W-1:0] = pend_q;
    endcase
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      led_q <= '0;
      ien_q <= '0;
      pend_q <= '0;
      evt_q <= '0;
      ack_q <= 1'b0;
    end else begin
      evt_q <= evt_i;
      ack_q <= acc;
      // new edges win over a write-one clear
      if (acc && req_i.we && req_i.adr[3:2] == 2'd3) begin
        pend_q <= (pend_q & ~req_i.dat[`IO_IRQ_W-1:0]) | evt_rise;
      end else begin
        pend_q <= pend_q | evt_rise;
      end
      if (acc && req_i.we && req_i.adr[3:2] == 2'd1) begin
        led_q <= req_i.dat[8:0];
      end
      if (acc && req_i.we && req_i.adr[3:2] == 2'd2) begin
        ien_q <= req_i.dat[`IO_IRQ_W-1:0];
      end
    end
  end

  always_ff @(posedge sysclock) begin
    if (acc) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o = '{dat: rdata_q, ack: ack_q};
  assign led_o = led_q;
  assign irq_o = pend_q & ien_q;

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
  input  logic sysclock,
  input  logic rst_i,
  input  logic cpu_req_i,
  input  logic disp_req_i,
  input  logic ack_i,
  output logic cpu_gnt_o,
  output logic disp_gnt_o
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_CPU,
    ARB_DISP
  } arb_state_t;

  arb_state_t state_q, state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE: begin
        // display refresh has priority
        if (disp_req_i) begin
          state_d = ARB_DISP;
        end else if (cpu_req_i) begin
          state_d = ARB_CPU;
        end
      end
      ARB_CPU, ARB_DISP: begin
        if (ack_i) begin
          state_d = ARB_IDLE;
        end
      end
      default: state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ARB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign cpu_gnt_o = (state_q == ARB_CPU);
  assign disp_gnt_o = (state_q == ARB_DISP);

endmodule

//--- src/shared_mem.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module shared_mem (
  input  logic              sysclock,
  input  logic              rst_i,
  input  soc_pkg::bus_req_t req_i,
  input  logic              stb_i,
  output soc_pkg::bus_rsp_t rsp_o
);

  import soc_pkg::*;

  localparam int AW = $clog2(`SMEM_DEPTH);
  localparam int CNT_W = $clog2(`SMEM_LATENCY + 1);

  logic [31:0]      mem [`SMEM_DEPTH];
  logic [31:0]      rdata_q;
  logic [CNT_W-1:0] cnt_q;
  logic             done_q, ack_q, hit;
  logic [AW-1:0]    idx;

  // frame buffer starts blank
  initial begin
    for (int n = 0; n < `SMEM_DEPTH; n++) begin
      mem[n] = '0;
    end
  end

  assign idx = req_i.adr[AW+1:2];
  assign hit = stb_i && !done_q && cnt_q == CNT_W'(`SMEM_LATENCY - 1);

  // one ack per strobe, rearm once stb drops
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
      done_q <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
      if (!stb_i) begin
        cnt_q <= '0;
        done_q <= 1'b0;
      end else if (hit) begin
        cnt_q <= '0;
        done_q <= 1'b1;
      end else if (!done_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge sysclock) begin
    if (hit) begin
      rdata_q <= mem[idx];
      for (int b = 0; b < 4; b++) begin
        if (req_i.we && req_i.sel[b]) begin
          mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
        end
      end
    end
  end

  assign rsp_o = '{dat: rdata_q, ack: ack_q};

endmodule

//--- src/scan_fetch.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module scan_fetch (
  input  logic              sysclock,
  input  logic              rst_i,
  output soc_pkg::bus_req_t req_o,
  output logic              cyc_o,
  input  soc_pkg::bus_rsp_t rsp_i,
  output logic [31:0]       pixel_o,
  output logic              pixel_valid_o
);

  import soc_pkg::*;

  localparam int FW_W = $clog2(`FRAME_WORDS);
  localparam int IDLE_CYCLES = 4;
  localparam int WAIT_W = $clog2(IDLE_CYCLES);

  logic [FW_W-1:0]   word_q;
  logic [WAIT_W-1:0] wait_q;
  logic              started_q, cyc_q, pvalid_q;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      word_q <= '0;
      wait_q <= '0;
      started_q <= 1'b0;
      cyc_q <= 1'b0;
      pvalid_q <= 1'b0;
    end else begin
      pvalid_q <= cyc_q & rsp_i.ack;
      if (!started_q) begin
        wait_q <= wait_q + 1'b1;
        if (wait_q == WAIT_W'(IDLE_CYCLES - 1)) begin
          started_q <= 1'b1;
          cyc_q <= 1'b1;
        end
      end else if (cyc_q && rsp_i.ack) begin
        // drop cyc for a cycle so the cpu can win the idle slot
        cyc_q <= 1'b0;
        word_q <= (word_q == FW_W'(`FRAME_WORDS - 1)) ? '0 : word_q + 1'b1;
      end else if (!cyc_q) begin
        cyc_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge sysclock) begin
    if (cyc_q && rsp_i.ack) begin
      pixel_o <= rsp_i.dat;
    end
  end

  assign req_o = '{adr: {`REGION_SMEM, {(26 - FW_W){1'b0}}, word_q, 2'b00},
                   dat: '0, sel: 4'hf, we: 1'b0};
  assign cyc_o = cyc_q;
  assign pixel_valid_o = pvalid_q;

endmodule

//--- src/soc_fabric.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module soc_fabric (
  input  logic                  sysclock,
  input  logic                  rst_i,
  input  soc_pkg::bus_req_t     cpu_req_i,
  input  logic                  cpu_cyc_i,
  output soc_pkg::bus_rsp_t     cpu_rsp_o,
  output logic [2:0]            cpu_irq_o,
  output logic                  fault_o,
  input  logic [15:0]           sw_i,
  input  logic [`IO_IRQ_W-1:0]  evt_i,
  output logic [8:0]            led_o,
  output logic [31:0]           pixel_o,
  output logic                  pixel_valid_o
);

  import soc_pkg::*;

  chip_sel_t            chip_sel;
  logic                 fault, vect_stb, rom_stb, io_stb, smem_stb;
  logic                 vect_rd, rom_rd, clear, cpu_gnt, disp_gnt, disp_cyc;
  logic [31:0]          vect_dat, rom_dat;
  logic                 vect_ack, rom_ack;
  logic [`IO_IRQ_W-1:0] io_irq;
  bus_rsp_t             io_rsp, smem_rsp, disp_rsp;
  bus_req_t             disp_req, smem_req;

  addr_decode u_addr_decode (.adr_i(cpu_req_i.adr), .cyc_i(cpu_cyc_i),
    .chip_sel_o(chip_sel), .fault_o(fault));

  assign vect_stb = (chip_sel == CS_VECT);
  assign rom_stb = (chip_sel == CS_ROM);
  assign io_stb = (chip_sel == CS_IO);
  assign smem_stb = (chip_sel == CS_SMEM);
  assign vect_rd = vect_stb & cpu_cyc_i & ~cpu_req_i.we;
  assign rom_rd = rom_stb & cpu_cyc_i & ~cpu_req_i.we;
  assign clear = (chip_sel == CS_NONE);

  onchip_mem #(.DEPTH(`VECT_DEPTH)) u_vect (.sysclock(sysclock), .rst_i(rst_i),
    .rden_i(vect_rd), .clear_i(clear), .adr_i(cpu_req_i.adr[$clog2(`VECT_DEPTH)+1:2]),
    .dat_o(vect_dat), .ack_o(vect_ack));

  onchip_mem #(.DEPTH(`ROM_DEPTH)) u_rom (.sysclock(sysclock), .rst_i(rst_i),
    .rden_i(rom_rd), .clear_i(clear), .adr_i(cpu_req_i.adr[$clog2(`ROM_DEPTH)+1:2]),
    .dat_o(rom_dat), .ack_o(rom_ack));

  io_regs u_io (.sysclock(sysclock), .rst_i(rst_i), .req_i(cpu_req_i), .stb_i(io_stb),
    .cyc_i(cpu_cyc_i), .rsp_o(io_rsp), .sw_i(sw_i), .evt_i(evt_i), .led_o(led_o),
    .irq_o(io_irq));

  mem_arbiter u_arb (.sysclock(sysclock), .rst_i(rst_i), .cpu_req_i(smem_stb),
    .disp_req_i(disp_cyc), .ack_i(smem_rsp.ack), .cpu_gnt_o(cpu_gnt),
    .disp_gnt_o(disp_gnt));

  // granted master drives the shared memory
  assign smem_req = cpu_gnt ? cpu_req_i : disp_req;

  shared_mem u_smem (.sysclock(sysclock), .rst_i(rst_i), .req_i(smem_req),
    .stb_i(cpu_gnt | disp_gnt), .rsp_o(smem_rsp));

  assign disp_rsp = '{dat: smem_rsp.dat, ack: smem_rsp.ack & disp_gnt};

  scan_fetch u_scan (.sysclock(sysclock), .rst_i(rst_i), .req_o(disp_req),
    .cyc_o(disp_cyc), .rsp_i(disp_rsp), .pixel_o(pixel_o),
    .pixel_valid_o(pixel_valid_o));

  // unmapped cycles get no ack
  assign cpu_rsp_o.dat = (vect_stb ? vect_dat : 32'h0) |
                         (rom_stb ? rom_dat : 32'h0) |
                         (io_stb ? io_rsp.dat : 32'h0) |
                         (smem_stb ? smem_rsp.dat : 32'h0);
  assign cpu_rsp_o.ack = (vect_stb & vect_ack) |
                         (rom_stb & rom_ack) |
                         (io_stb & io_rsp.ack) |
                         (smem_stb & smem_rsp.ack & cpu_gnt);

  // fault masks the io interrupt level
  always_comb begin
    if (fault) begin
      cpu_irq_o = 3'h0;
    end else if (|io_irq) begin
      cpu_irq_o = {1'b1, io_irq};
    end else begin
      cpu_irq_o = 3'h0;
    end
  end

  assign fault_o = fault;

endmodule

//--- bench/tb_soc_fabric.sv
`timescale 1ns/10ps
`include "soc_macros.svh"

module tb_soc_fabric;

  import soc_pkg::*;

  localparam int N_ONCHIP = 24;
  localparam int N_SMEM = 32;
  localparam int N_ACCESSES = 150;
  // about 20 cycles per access plus room for display traffic
  localparam int TIMEOUT_CYCLES = N_ACCESSES * 20 + 1000;

  logic                 sysclock;
  logic                 rst;
  bus_req_t             cpu_req;
  logic                 cpu_cyc;
  bus_rsp_t             cpu_rsp;
  logic [2:0]           cpu_irq;
  logic                 fault;
  logic [15:0]          sw;
  logic [`IO_IRQ_W-1:0] evt;
  logic [8:0]           led;
  logic [31:0]          pixel;
  logic                 pixel_valid;

  logic [31:0] smem_model [`SMEM_DEPTH];
  int err_cnt = 0;
  int bg_err = 0;
  int tests_ok = 0;
  int tests_bad = 0;
  int cycle_cnt = 0;
  int pix_cnt = 0;
  int frame_idx = 0;

  soc_fabric u_soc_fabric (
    .sysclock(sysclock), .rst_i(rst), .cpu_req_i(cpu_req), .cpu_cyc_i(cpu_cyc),
    .cpu_rsp_o(cpu_rsp), .cpu_irq_o(cpu_irq), .fault_o(fault), .sw_i(sw),
    .evt_i(evt), .led_o(led), .pixel_o(pixel), .pixel_valid_o(pixel_valid)
  );

  initial begin
    sysclock = 1'b0;
    forever #50 sysclock = ~sysclock;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge sysclock);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

  // the two masters never share the memory
  assert property (@(posedge sysclock) disable iff (rst)
    !(u_soc_fabric.cpu_gnt && u_soc_fabric.disp_gnt))
    else begin
      $display("both shared memory grants were high at %0t", $time);
      bg_err++;
    end

  assert property (@(posedge sysclock) disable iff (rst) cpu_rsp.ack |=> !cpu_rsp.ack)
    else begin
      $display("cpu acknowledge at %0t lasted more than one cycle", $time);
      bg_err++;
    end

  assert property (@(posedge sysclock) disable iff (rst)
    fault |-> (!cpu_rsp.ack && cpu_irq == 3'h0))
    else begin
      $display("mismatch at %0t: fault with ack %b irq %0d", $time, cpu_rsp.ack, cpu_irq);
      bg_err++;
    end

  // display words walk the frame in order and wrap
  always @(negedge sysclock) begin
    if (!rst && pixel_valid) begin
      assert (pixel === smem_model[frame_idx]) else begin
        $display("mismatch at %0t: pixel word %0d got %h expected %h", $time, frame_idx,
                 pixel, smem_model[frame_idx]);
        bg_err++;
      end
      frame_idx = (frame_idx + 1) % `FRAME_WORDS;
      pix_cnt++;
    end
  end

  // index repeated in every byte, depth added into the top byte
  function automatic logic [31:0] onchip_word(input int n, input int depth);
    logic [7:0] b;
    b = 8'(n);
    return {b + 8'(depth), b, b, b};
  endfunction

  function automatic logic [31:0] byte_merge(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [2:0] irq_level(input logic [`IO_IRQ_W-1:0] lines,
                                           input logic flt);
    if (flt || lines == '0) begin
      return 3'h0;
    end
    return {1'b1, lines};
  endfunction

  function automatic logic [31:0] io_adr(input int off);
    return {`REGION_IO, 24'h0, 2'(off), 2'b00};
  endfunction

  function automatic logic [31:0] smem_adr_of(input int w);
    return {`REGION_SMEM, 16'h0, 10'(w), 2'b00};
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge sysclock);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // lat counts rising edges from the request to the visible ack
  task automatic bus_access(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we,
                            output logic [31:0] rdata, output int lat);
    @(posedge sysclock);
    cpu_req <= '{adr: adr, dat: dat, sel: sel, we: we};
    cpu_cyc <= 1'b1;
    lat = 0;
    @(negedge sysclock);
    while (!cpu_rsp.ack) begin
      lat++;
      @(negedge sysclock);
    end
    rdata = cpu_rsp.dat;
    @(posedge sysclock);
    cpu_cyc <= 1'b0;
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("%s: ok", name);
      tests_ok++;
    end else begin
      $display("%s: %0d errors", name, errs);
      tests_bad++;
    end
  endtask

  initial begin
    logic [31:0]          rd;
    logic [31:0]          wdat;
    logic [3:0]           wsel;
    logic [8:0]           led_val;
    logic [`IO_IRQ_W-1:0] ien_m;
    logic [`IO_IRQ_W-1:0] pend_m;
    int                   lat;
    int                   w;
    int                   mark;
    int                   smem_adr [N_SMEM];

    rst = 1'b1;
    cpu_req = '0;
    cpu_cyc = 1'b0;
    sw = '0;
    evt = '0;
    void'($urandom(32'h49c2de62));
    for (int n = 0; n < `SMEM_DEPTH; n++) begin
      smem_model[n] = '0;
    end

    mark = err_cnt;
    wait_cycles(10);
    rst <= 1'b0;
    @(negedge sysclock);
    check_value("ack after reset", 32'(cpu_rsp.ack), 32'd0);
    check_value("cpu grant after reset", 32'(u_soc_fabric.cpu_gnt), 32'd0);
    check_value("display grant after reset", 32'(u_soc_fabric.disp_gnt), 32'd0);
    check_value("pixel valid after reset", 32'(pixel_valid), 32'd0);
    check_value("fault after reset", 32'(fault), 32'd0);
    check_value("irq after reset", 32'(cpu_irq), 32'd0);
    check_value("leds after reset", 32'(led), 32'd0);
    report_test("reset", err_cnt - mark);

    mark = err_cnt;
    for (int i = 0; i < N_ONCHIP; i++) begin
      if (i % 2 == 0) begin
        w = $urandom_range(`VECT_DEPTH - 1, 0);
        bus_access({`REGION_VECT, 28'(w * 4)}, '0, 4'hf, 1'b0, rd, lat);
        check_value("vector word", rd, onchip_word(w, `VECT_DEPTH));
      end else begin
        w = $urandom_range(`ROM_DEPTH - 1, 0);
        bus_access({`REGION_ROM, 28'(w * 4)}, '0, 4'hf, 1'b0, rd, lat);
        check_value("rom word", rd, onchip_word(w, `ROM_DEPTH));
      end
      check_value("onchip ack latency", 32'(lat), 32'd2);
    end
    report_test("onchip_reads", err_cnt - mark);

    mark = err_cnt;
    @(posedge sysclock);
    sw <= 16'($urandom);
    bus_access(io_adr(0), '0, 4'hf, 1'b0, rd, lat);
    check_value("switch read", rd, {16'h0, sw});
    check_value("io ack latency", 32'(lat), 32'd1);
    led_val = 9'($urandom);
    bus_access(io_adr(1), {23'h0, led_val}, 4'hf, 1'b1, rd, lat);
    check_value("io ack latency", 32'(lat), 32'd1);
    @(negedge sysclock);
    check_value("led output", 32'(led), 32'(led_val));
    bus_access(io_adr(1), '0, 4'hf, 1'b0, rd, lat);
    check_value("led read back", rd, 32'(led_val));
    check_value("io ack latency", 32'(lat), 32'd1);
    report_test("io_registers", err_cnt - mark);

    mark = err_cnt;
    ien_m = 2'b11;
    pend_m = 2'b00;
    bus_access(io_adr(2), 32'(ien_m), 4'hf, 1'b1, rd, lat);
    @(posedge sysclock);
    evt <= 2'b01;
    pend_m = pend_m | 2'b01;
    wait_cycles(3);
    @(negedge sysclock);
    check_value("irq after event 0", 32'(cpu_irq), 32'(irq_level(pend_m & ien_m, 1'b0)));
    bus_access(io_adr(3), '0, 4'hf, 1'b0, rd, lat);
    check_value("pending read", rd, 32'(pend_m));
    bus_access(io_adr(3), 32'h1, 4'hf, 1'b1, rd, lat);
    pend_m = pend_m & ~2'b01;
    @(negedge sysclock);
    check_value("irq after clear", 32'(cpu_irq), 32'(irq_level(pend_m & ien_m, 1'b0)));
    @(posedge sysclock);
    evt <= 2'b10;
    pend_m = pend_m | 2'b10;
    wait_cycles(3);
    @(negedge sysclock);
    check_value("irq after event 1", 32'(cpu_irq), 32'(irq_level(pend_m & ien_m, 1'b0)));
    // unmapped region held like a stalled cpu
    @(posedge sysclock);
    cpu_req <= '{adr: 32'h2000_0000, dat: '0, sel: 4'hf, we: 1'b0};
    cpu_cyc <= 1'b1;
    repeat (6) begin
      @(negedge sysclock);
      check_value("fault flag", 32'(fault), 32'd1);
      check_value("irq under fault", 32'(cpu_irq), 32'(irq_level(pend_m & ien_m, 1'b1)));
      assert (!cpu_rsp.ack) else begin
        $display("unmapped access was acknowledged at %0t", $time);
        err_cnt++;
      end
    end
    @(posedge sysclock);
    cpu_cyc <= 1'b0;
    @(negedge sysclock);
    check_value("fault cleared", 32'(fault), 32'd0);
    check_value("irq restored", 32'(cpu_irq), 32'(irq_level(pend_m & ien_m, 1'b0)));
    bus_access(io_adr(3), 32'h2, 4'hf, 1'b1, rd, lat);
    pend_m = pend_m & ~2'b10;
    evt <= '0;
    @(negedge sysclock);
    check_value("irq after last clear", 32'(cpu_irq), 32'(irq_level(pend_m & ien_m, 1'b0)));
    report_test("interrupts", err_cnt - mark);

    mark = err_cnt;
    for (int i = 0; i < N_SMEM; i++) begin
      smem_adr[i] = $urandom_range(2 * `FRAME_WORDS - 1, 0);
      wdat = $urandom;
      wsel = 4'($urandom);
      bus_access(smem_adr_of(smem_adr[i]), wdat, wsel, 1'b1, rd, lat);
      smem_model[smem_adr[i]] = byte_merge(smem_model[smem_adr[i]], wdat, wsel);
    end
    for (int i = 0; i < N_SMEM; i++) begin
      bus_access(smem_adr_of(smem_adr[i]), '0, 4'hf, 1'b0, rd, lat);
      check_value("shared memory read", rd, smem_model[smem_adr[i]]);
    end
    report_test("shared_memory", err_cnt - mark);

    // at least one full frame plus the wrap
    while (pix_cnt < `FRAME_WORDS + 8) begin
      @(posedge sysclock);
    end
    report_test("display_fetch", bg_err);

    $display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
    if (tests_bad == 0 && err_cnt == 0 && bg_err == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+src
src/soc_pkg.sv
src/addr_decode.sv
src/onchip_mem.sv
src/io_regs.sv
src/mem_arbiter.sv
src/shared_mem.sv
src/scan_fetch.sv
src/soc_fabric.sv
bench/tb_soc_fabric.sv

//--- Makefile
# Verilator build and run for the bus fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_fabric
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
